// ==== test/map_trace.txt ====
# op addr data levels dip expected, all hex; W write, R read, C output check
# levels bits 8..0 are coin p2_start p1_start special fire up down right left
C c800 00 000 00 0000
C c802 00 000 00 0000
C c806 00 000 00 0000
W c800 5a 000 00 0000
R c800 00 000 00 005a
C c800 00 000 00 005a
W c802 34 000 00 0000
W c803 12 000 00 0000
R c803 00 000 00 0012
C c802 00 000 00 1234
W c804 a5 000 00 0000
R c804 00 000 00 00a5
W c805 c3 000 00 0000
C c805 00 000 00 0003
W c806 ff 000 00 0000
R c806 00 000 00 0003
C c806 00 000 00 0003
R c000 00 1c5 00 007c
R c001 00 1c5 00 00fa
R c002 00 1c5 00 00fa
R c001 00 03a 00 00c5
R c000 00 040 00 00fe
R c003 00 000 00 00ff
R c004 00 000 01 00f7
R c004 00 000 fe 00ff
W cc05 11 000 00 0000
W d005 22 000 00 0000
W d805 33 000 00 0000
W e005 44 000 00 0000
W d7ff 88 000 00 0000
W efff 99 000 00 0000
R cc05 00 000 00 0011
R d005 00 000 00 0022
R d805 00 000 00 0033
R e005 00 000 00 0044
R d7ff 00 000 00 0088
R efff 00 000 00 0099
R 0000 00 000 00 0000
R bfff 00 000 00 0000
R cc80 00 000 00 0000
W c001 77 000 00 0000
R c001 00 000 00 00ff
W c801 55 000 00 0000
R c801 00 000 00 0000
W f000 66 000 00 0000
R f000 00 000 00 0000
R c800 00 000 00 005a

// ==== compile.f ====
+incdir+hdl
hdl/map_pkg.sv
hdl/io_pkg.sv
hdl/map_decoder.sv
hdl/ctrl_regs.sv
hdl/byte_ram.sv
hdl/video_work_ram.sv
hdl/bus_response.sv
hdl/main_cpu_map.sv
test/tb_main_cpu_map.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_main_cpu_map -f compile.f
out=$(./obj_dir/Vtb_main_cpu_map 2>&1) || true
echo "$out"
if echo "$out" | grep -qx 'All tests passed!'; then
  exit 0
else
  exit 1
fi

// ==== test/tb_main_cpu_map.sv ====
`timescale 1ns/10ps

`include "map_defs.svh"

module tb_main_cpu_map;

  import map_pkg::*;
  import io_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int READY_TIMEOUT = 20;  // access cycles

  logic       cpu_clk;
  logic       rst_b;
  logic       psel;
  logic       penable;
  logic       pwrite;
  cpu_addr_t  paddr;
  byte_t      pwdata;
  byte_t      prdata;
  logic       pready;
  logic [8:0] levels;  // coin p2_start p1_start special fire up down right left
  byte_t      dip;
  byte_t      soundlatch;
  scroll_t    scroll;
  pal_bank_t  pal_bank;
  bank_sel_t  bank_sel;

  main_cpu_map DUT (
    .cpu_clk    (cpu_clk),
    .rst_b      (rst_b),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .up         (levels[3]),
    .down       (levels[2]),
    .left       (levels[0]),
    .right      (levels[1]),
    .fire       (levels[4]),
    .special    (levels[5]),
    .p1_start   (levels[6]),
    .p2_start   (levels[7]),
    .coin       (levels[8]),
    .dip        (dip),
    .soundlatch (soundlatch),
    .scroll     (scroll),
    .pal_bank   (pal_bank),
    .bank_sel   (bank_sel)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR at %0t: %s is %02h, expected %02h", $time, what, got, exp));
  endtask

  task automatic check_scroll(input string what, input scroll_t got, input scroll_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR at %0t: %s is %04h, expected %04h", $time, what, got, exp));
  endtask

  task automatic check_bank(input string what, input bank_sel_t got, input bank_sel_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic verify_pal_bank(input pal_bank_t got, input pal_bank_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR at %0t: pal_bank is %0d, expected %0d", $time, got, exp));
  endtask

  task automatic check_latency(input cpu_addr_t addr, input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("ERROR at %0t: pready at %04h after %0d access cycles, expected %0d",
                         $time, addr, got, exp));
  endtask

  // ram windows take one wait state
  function automatic bit in_ram(input cpu_addr_t a);
    return (a >= `SPRITE_BASE && a <= `SPRITE_TOP) || (a >= `FG_BASE && a <= `FG_TOP) ||
           (a >= `BG_BASE && a <= `BG_TOP) || (a >= `WORK_BASE && a <= `WORK_TOP);
  endfunction

  // called on a falling edge, returns on the falling edge after completion
  task automatic apb_transfer(input logic wr, input cpu_addr_t addr, input byte_t wdata,
                              output byte_t rdata, output int cycles);
    logic ready;
    psel    = 1'b1;  // setup cycle
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge cpu_clk);
    penable = 1'b1;
    cycles  = 0;
    ready   = 1'b0;
    rdata   = '0;
    while (!ready) begin
      #(CLK_PERIOD / 4);  // settled, well before the rising edge
      cycles++;
      ready = (pready === 1'b1);
      rdata = prdata;
      if (!ready && cycles >= READY_TIMEOUT)
        stop_run($sformatf("the slave never became ready for address %04h", addr));
      @(negedge cpu_clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  initial begin
    string       op;
    string       skip;
    int          fd;
    int          n;
    int          idle;
    int          cycles;
    logic [15:0] addr_f;
    logic [7:0]  data_f;
    logic [8:0]  lvl_f;
    logic [7:0]  dip_f;
    logic [15:0] exp_f;
    byte_t       rd;

    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    levels  = '0;
    dip     = '0;
    rst_b   = 1'b0;
    void'($urandom(11483));

    repeat (16) @(negedge cpu_clk);
    rst_b = 1'b1;
    @(negedge cpu_clk);
    if (pready !== 1'b0)
      stop_run($sformatf("ERROR at %0t: pready is high before any transfer", $time));
    check_byte("prdata after reset", prdata, 8'h00);

    fd = $fopen("test/map_trace.txt", "r");
    if (fd == 0)
      stop_run("could not open the trace file test/map_trace.txt");

    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1)
        break;
      if (op == "#") begin
        n = $fgets(skip, fd);  // rest of a comment line
        continue;
      end
      n = $fscanf(fd, "%h %h %h %h %h", addr_f, data_f, lvl_f, dip_f, exp_f);
      if (n != 5)
        stop_run("a trace line has fewer than six fields");
      levels = lvl_f;
      dip    = dip_f;
      if (op == "W" || op == "R") begin
        apb_transfer(op == "W", addr_f, data_f, rd, cycles);
        check_latency(addr_f, cycles, in_ram(addr_f) ? 2 : 1);
        if (op == "R")
          check_byte($sformatf("prdata at %04h", addr_f), rd, exp_f[7:0]);
      end else if (op == "C") begin
        // addr picks the output to look at
        if (addr_f == `SOUNDLATCH_ADDR)
          check_byte("soundlatch", soundlatch, exp_f[7:0]);
        else if (addr_f == `SCROLL_LO_ADDR)
          check_scroll("scroll", scroll, exp_f);
        else if (addr_f == `PAL_BANK_ADDR)
          verify_pal_bank(pal_bank, exp_f[1:0]);
        else if (addr_f == `BANK_SEL_ADDR)
          check_bank("bank_sel", bank_sel, exp_f[1:0]);
        else
          stop_run("the trace asks for an output that does not exist");
      end else begin
        stop_run("the trace holds an unknown operation");
      end
      idle = $urandom % 4;
      repeat (idle) @(negedge cpu_clk);
    end
    $fclose(fd);

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== hdl/main_cpu_map.sv ====
`timescale 1ns/10ps

module main_cpu_map (
  input  logic                cpu_clk,
  input  logic                rst_b,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  map_pkg::cpu_addr_t  paddr,
  input  map_pkg::byte_t      pwdata,
  output map_pkg::byte_t      prdata,
  output logic                pready,
  input  logic                up,
  input  logic                down,
  input  logic                left,
  input  logic                right,
  input  logic                fire,
  input  logic                special,
  input  logic                p1_start,
  input  logic                p2_start,
  input  logic                coin,
  input  map_pkg::byte_t      dip,
  output map_pkg::byte_t      soundlatch,
  output io_pkg::scroll_t     scroll,
  output io_pkg::pal_bank_t   pal_bank,
  output io_pkg::bank_sel_t   bank_sel
);

  import map_pkg::*;

  region_t region;
  byte_t   reg_rdata;
  byte_t   ram_rdata;
  logic    reg_we;
  logic    ram_we;

  map_decoder u_decoder (
    .paddr  (paddr),
    .region (region)
  );

  ctrl_regs u_ctrl_regs (
    .cpu_clk    (cpu_clk),
    .rst_b      (rst_b),
    .region     (region),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .reg_we     (reg_we),
    .up         (up),
    .down       (down),
    .left       (left),
    .right      (right),
    .fire       (fire),
    .special    (special),
    .p1_start   (p1_start),
    .p2_start   (p2_start),
    .coin       (coin),
    .dip        (dip),
    .reg_rdata  (reg_rdata),
    .soundlatch (soundlatch),
    .scroll     (scroll),
    .pal_bank   (pal_bank),
    .bank_sel   (bank_sel)
  );

  video_work_ram u_rams (
    .cpu_clk   (cpu_clk),
    .region    (region),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata)
  );

  bus_response u_bus_response (
    .cpu_clk   (cpu_clk),
    .rst_b     (rst_b),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .region    (region),
    .reg_rdata (reg_rdata),
    .ram_rdata (ram_rdata),
    .reg_we    (reg_we),
    .ram_we    (ram_we),
    .prdata    (prdata),
    .pready    (pready)
  );

endmodule

// ==== hdl/bus_response.sv ====
`timescale 1ns/10ps

module bus_response (
  input  logic              cpu_clk,
  input  logic              rst_b,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  map_pkg::region_t  region,
  input  map_pkg::byte_t    reg_rdata,
  input  map_pkg::byte_t    ram_rdata,
  output logic              reg_we,
  output logic              ram_we,
  output map_pkg::byte_t    prdata,
  output logic              pready
);

  import map_pkg::*;

  logic access;
  logic is_ram;
  logic ram_wait;  // set during the second access cycle of a ram transfer

  assign access = psel && penable;
  assign is_ram = region inside {RGN_SPRITE, RGN_FG, RGN_BG, RGN_WORK};

  // one wait state, then clear again on completion
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      ram_wait <= 1'b0;
    end else begin
      ram_wait <= access && is_ram && !ram_wait;
    end
  end

  assign pready = access && (!is_ram || ram_wait);

  assign reg_we = pready && pwrite && (region == RGN_REG);
  assign ram_we = pready && pwrite && is_ram;

  always_comb begin
    prdata = '0;
    if (pready) begin
      if (region == RGN_REG || region == RGN_PORT) begin
        prdata = reg_rdata;
      end else if (is_ram) begin
        prdata = ram_rdata;
      end
    end
  end

endmodule

// ==== hdl/video_work_ram.sv ====
`timescale 1ns/10ps

`include "map_defs.svh"

module video_work_ram (
  input  logic                cpu_clk,
  input  map_pkg::region_t    region,
  input  map_pkg::cpu_addr_t  paddr,
  input  map_pkg::byte_t      pwdata,
  input  logic                ram_we,
  output map_pkg::byte_t      ram_rdata
);

  import map_pkg::*;

  region_t region_q;  // lines up with the registered ram output
  byte_t   sprite_rdata;
  byte_t   fg_rdata;
  byte_t   bg_rdata;
  byte_t   work_rdata;

  byte_ram #(.ADDR_W(`SPRITE_AW)) u_sprite_ram (
    .cpu_clk (cpu_clk),
    .we      (ram_we && (region == RGN_SPRITE)),
    .addr    (paddr[`SPRITE_AW-1:0]),
    .wdata   (pwdata),
    .rdata   (sprite_rdata)
  );

  byte_ram #(.ADDR_W(`FG_AW)) u_fg_ram (
    .cpu_clk (cpu_clk),
    .we      (ram_we && (region == RGN_FG)),
    .addr    (paddr[`FG_AW-1:0]),
    .wdata   (pwdata),
    .rdata   (fg_rdata)
  );

  byte_ram #(.ADDR_W(`BG_AW)) u_bg_ram (
    .cpu_clk (cpu_clk),
    .we      (ram_we && (region == RGN_BG)),
    .addr    (paddr[`BG_AW-1:0]),
    .wdata   (pwdata),
    .rdata   (bg_rdata)
  );

  byte_ram #(.ADDR_W(`WORK_AW)) u_work_ram (
    .cpu_clk (cpu_clk),
    .we      (ram_we && (region == RGN_WORK)),
    .addr    (paddr[`WORK_AW-1:0]),
    .wdata   (pwdata),
    .rdata   (work_rdata)
  );

  always_ff @(posedge cpu_clk) begin
    region_q <= region;
  end

  always_comb begin
    case (region_q)
      RGN_SPRITE: ram_rdata = sprite_rdata;
      RGN_FG:     ram_rdata = fg_rdata;
      RGN_BG:     ram_rdata = bg_rdata;
      RGN_WORK:   ram_rdata = work_rdata;
      default:    ram_rdata = '0;
    endcase
  end

endmodule

// ==== hdl/byte_ram.sv ====
`timescale 1ns/10ps

module byte_ram #(
  parameter int ADDR_W = 10
) (
  input  logic                cpu_clk,
  input  logic                we,
  input  logic [ADDR_W-1:0]   addr,
  input  map_pkg::byte_t      wdata,
  output map_pkg::byte_t      rdata
);

  import map_pkg::*;

  byte_t mem [2**ADDR_W];

  always_ff @(posedge cpu_clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;  // write first
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== hdl/ctrl_regs.sv ====
`timescale 1ns/10ps

`include "map_defs.svh"

module ctrl_regs (
  input  logic                cpu_clk,
  input  logic                rst_b,
  input  map_pkg::region_t    region,
  input  map_pkg::cpu_addr_t  paddr,
  input  map_pkg::byte_t      pwdata,
  input  logic                reg_we,
  input  logic                up,
  input  logic                down,
  input  logic                left,
  input  logic                right,
  input  logic                fire,
  input  logic                special,
  input  logic                p1_start,
  input  logic                p2_start,
  input  logic                coin,
  input  map_pkg::byte_t      dip,
  output map_pkg::byte_t      reg_rdata,
  output map_pkg::byte_t      soundlatch,
  output io_pkg::scroll_t     scroll,
  output io_pkg::pal_bank_t   pal_bank,
  output io_pkg::bank_sel_t   bank_sel
);

  import map_pkg::*;

  byte_t spare_q;
  byte_t pal_q;    // full byte kept for readback
  logic  load;

  assign load = reg_we && (region == RGN_REG);

  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      soundlatch <= '0;
      scroll     <= '0;
      spare_q    <= '0;
      pal_q      <= '0;
      bank_sel   <= '0;
    end else if (load) begin
      case (paddr)
        `SOUNDLATCH_ADDR: soundlatch <= pwdata;
        `SCROLL_LO_ADDR:  scroll.lo  <= pwdata;
        `SCROLL_HI_ADDR:  scroll.hi  <= pwdata;
        `SPARE_ADDR:      spare_q    <= pwdata;
        `PAL_BANK_ADDR:   pal_q      <= pwdata;
        `BANK_SEL_ADDR:   bank_sel   <= pwdata[1:0];
        default: ;
      endcase
    end
  end

  assign pal_bank = pal_q[1:0];

  // ports are active low, so everything is inverted
  always_comb begin
    reg_rdata = '0;
    if (region == RGN_REG || region == RGN_PORT) begin
      case (paddr)
        `SYS_PORT_ADDR:   reg_rdata = ~{coin, 5'b00000, p2_start, p1_start};
        `P1_PORT_ADDR,
        `P2_PORT_ADDR:    reg_rdata = ~{2'b00, special, fire, up, down, right, left};
        `DSWA_ADDR:       reg_rdata = 8'hFF;
        `DSWB_ADDR:       reg_rdata = ~{4'b0000, dip[0], 3'b000}; // test mode switch
        `SOUNDLATCH_ADDR: reg_rdata = soundlatch;
        `SCROLL_LO_ADDR:  reg_rdata = scroll.lo;
        `SCROLL_HI_ADDR:  reg_rdata = scroll.hi;
        `SPARE_ADDR:      reg_rdata = spare_q;
        `PAL_BANK_ADDR:   reg_rdata = pal_q;
        `BANK_SEL_ADDR:   reg_rdata = {6'b000000, bank_sel};
        default:          reg_rdata = '0;
      endcase
    end
  end

endmodule

// ==== hdl/map_decoder.sv ====
`timescale 1ns/10ps

`include "map_defs.svh"

module map_decoder (
  input  map_pkg::cpu_addr_t paddr,
  output map_pkg::region_t   region
);

  import map_pkg::*;

  logic is_reg;
  logic is_port;

  // c801 is a hole between the registers
  assign is_reg = (paddr == `SOUNDLATCH_ADDR) ||
                  (paddr == `SCROLL_LO_ADDR)  ||
                  (paddr == `SCROLL_HI_ADDR)  ||
                  (paddr == `SPARE_ADDR)      ||
                  (paddr == `PAL_BANK_ADDR)   ||
                  (paddr == `BANK_SEL_ADDR);

  assign is_port = (paddr >= `SYS_PORT_ADDR) && (paddr <= `DSWB_ADDR);

  always_comb begin
    if (is_reg) begin
      region = RGN_REG;
    end else if (is_port) begin
      region = RGN_PORT;
    end else if (paddr >= `SPRITE_BASE && paddr <= `SPRITE_TOP) begin
      region = RGN_SPRITE;
    end else if (paddr >= `FG_BASE && paddr <= `FG_TOP) begin
      region = RGN_FG;
    end else if (paddr >= `BG_BASE && paddr <= `BG_TOP) begin
      region = RGN_BG;
    end else if (paddr >= `WORK_BASE && paddr <= `WORK_TOP) begin
      region = RGN_WORK;
    end else begin
      region = RGN_NONE; // rom and unused space
    end
  end

endmodule

// ==== hdl/io_pkg.sv ====
package io_pkg;

  // scroll as the video side sees it
  typedef struct packed {
    logic [7:0] hi;  // written at the high address
    logic [7:0] lo;
  } scroll_t;

  // rom bank for 0x8000-0xbfff
  typedef logic [1:0] bank_sel_t;

  // palette bank, only two bits go out
  typedef logic [1:0] pal_bank_t;

endpackage

// ==== hdl/map_pkg.sv ====
package map_pkg;

  // cpu data bus is one byte wide
  typedef logic [7:0] byte_t;

  // full z80 address space
  typedef logic [15:0] cpu_addr_t;

  // one class per decoded window
  typedef enum logic [2:0] {
    RGN_NONE,    // rom space and holes, reads zero
    RGN_REG,     // control registers
    RGN_PORT,    // joystick / dip ports
    RGN_SPRITE,
    RGN_FG,
    RGN_BG,
    RGN_WORK
  } region_t;

endpackage

// ==== hdl/map_defs.svh ====
`ifndef MAP_DEFS_SVH
`define MAP_DEFS_SVH

// control registers, write and read back
`define SOUNDLATCH_ADDR 16'hC800
`define SCROLL_LO_ADDR  16'hC802
`define SCROLL_HI_ADDR  16'hC803
`define SPARE_ADDR      16'hC804
`define PAL_BANK_ADDR   16'hC805
`define BANK_SEL_ADDR   16'hC806

// input ports, active low, read only
`define SYS_PORT_ADDR   16'hC000
`define P1_PORT_ADDR    16'hC001
`define P2_PORT_ADDR    16'hC002
`define DSWA_ADDR       16'hC003
`define DSWB_ADDR       16'hC004

// ram windows, top is inclusive
`define SPRITE_BASE     16'hCC00
`define SPRITE_TOP      16'hCC7F
`define FG_BASE         16'hD000
`define FG_TOP          16'hD7FF
`define BG_BASE         16'hD800
`define BG_TOP          16'hDBFF
`define WORK_BASE       16'hE000
`define WORK_TOP        16'hEFFF

`define SPRITE_AW       7   // 128 bytes
`define FG_AW           11  // video + color ram
`define BG_AW           10
`define WORK_AW         12

`endif
